// File: common/boolFuncPkg.sv
package boolFuncPkg;

    localparam int numVars   = 7;
    localparam int funcWidth = 128;  // 2**numVars minterms
    localparam int numLanes  = 6;    // 3! orderings of variables 4, 5 and 6
    localparam int popWidth  = 8;    // holds 0..128

    // bit i of a truth table is the value on minterm i
    // upper word covers minterms 64..127 (variable 6 set)
    typedef logic [funcWidth-1:0] boolFunc;

    // source minterm for output minterm idx in a lane
    // lane 0 leaves the order alone; 1..3 swap a pair; 4 and 5 rotate
    function automatic logic [numVars-1:0] permuteIndex(
        input int                 lane,
        input logic [numVars-1:0] idx
    );
        logic [numVars-1:0] src;
        src = idx;  // bits 0..3 never move
        case (lane)
            1: begin
                src[4] = idx[5];  // swap 4,5
                src[5] = idx[4];
            end
            2: begin
                src[4] = idx[6];  // swap 4,6
                src[6] = idx[4];
            end
            3: begin
                src[5] = idx[6];  // swap 5,6
                src[6] = idx[5];
            end
            4: begin
                src[4] = idx[5];
                src[5] = idx[6];
                src[6] = idx[4];
            end
            5: begin
                src[4] = idx[6];
                src[5] = idx[4];
                src[6] = idx[5];
            end
            default: ;
        endcase
        return src;
    endfunction

endpackage

// File: common/resultPkg.sv
package resultPkg;

    localparam int resultWidth    = 64;
    localparam int sumWidth       = 48;
    localparam int countWidth     = 13;
    localparam int botCountWidth  = 31;
    localparam int laneTotalWidth = 32;

    // per-bot result
    typedef struct packed {
        logic                  isTop;     // 0 here
        logic [1:0]            reserved;
        logic [countWidth-1:0] validCount;  // lanes that passed the subset test
        logic [sumWidth-1:0]   sum;
    } botFields;

    // summary for the top that was just replaced
    typedef struct packed {
        logic                      isTop;  // 1 here
        logic [botCountWidth-1:0]  botCount;
        logic [laneTotalWidth-1:0] laneTotal;
    } topFields;

    // msb selects which view applies
    typedef union packed {
        botFields botView;
        topFields topView;
    } resultWord;

    // both views must fill the full word
    localparam int botViewBits = $bits(botFields);
    localparam int topViewBits = $bits(topFields);

    typedef logic [resultWidth-1:0] resultBits;

endpackage

// File: src/botIngest.sv
`timescale 1ns/1ps

module botIngest (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 advance,
    input  logic                 inValid,
    input  logic                 startNewTop,
    input  logic [63:0]          botLower,
    input  logic [63:0]          botUpper,
    output logic                 stageValid,
    output logic                 stageIsTop,
    output boolFuncPkg::boolFunc stageBot,
    output boolFuncPkg::boolFunc currentTop
);

    logic topLeaving;

    // a flagged word becomes the top in force once it moves on to the lanes
    assign topLeaving = advance && stageValid && stageIsTop;

    always_ff @(posedge clock) begin
        if (!rst) begin
            stageValid <= 1'b0;
            stageIsTop <= 1'b0;
        end else if (advance) begin
            stageValid <= inValid;
            stageIsTop <= inValid && startNewTop;
        end
    end

    always_ff @(posedge clock) begin
        if (advance && inValid) begin
            stageBot <= {botUpper, botLower};
        end
    end

    // no top in force until the first flagged word
    always_ff @(posedge clock) begin
        if (!rst) begin
            currentTop <= '0;
        end else if (topLeaving) begin
            currentTop <= stageBot;
        end
    end

    // a word held back by a stall is offered again unchanged
    assert property (@(posedge clock) disable iff (!rst)
        inValid && !advance |=> inValid && $stable(startNewTop) && $stable(botLower)
            && $stable(botUpper));

endmodule

// File: permuteLane/permuteLane.sv
`timescale 1ns/1ps

module permuteLane #(
    parameter int laneIndex = 0
) (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             advance,
    input  logic                             stageValid,
    input  logic                             stageIsTop,
    input  boolFuncPkg::boolFunc             stageBot,
    input  boolFuncPkg::boolFunc             currentTop,
    output logic                             laneValidOut,
    output logic                             laneIsTop,
    output logic                             laneHit,
    output logic [boolFuncPkg::popWidth-1:0] laneCount
);
    import boolFuncPkg::*;

    boolFunc               permBot;
    logic                  isSubset;
    logic                  s1Valid;
    logic                  s1IsTop;
    logic                  s1Hit;
    boolFunc               s1Top;     // own copy, so a new top can't overtake
    boolFunc               s1Bot;
    boolFunc               diffBits;
    logic [popWidth-1:0]   onesCount;

    // stage 1 is pure rewiring of the minterms
    for (genvar i = 0; i < funcWidth; i++) begin : gPermute
        assign permBot[i] = stageBot[permuteIndex(laneIndex, numVars'(i))];
    end

    assign isSubset = (permBot & ~currentTop) == '0;

    always_ff @(posedge clock) begin
        if (!rst) begin
            s1Valid <= 1'b0;
            s1IsTop <= 1'b0;
        end else if (advance) begin
            s1Valid <= stageValid;
            s1IsTop <= stageIsTop;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            s1Hit <= isSubset && !stageIsTop;  // top words never score
            s1Top <= currentTop;
            s1Bot <= permBot;
        end
    end

    // stage 2 counts the ones of top that the bot leaves uncovered
    assign diffBits = s1Top & ~s1Bot;

    always_comb begin
        onesCount = '0;
        for (int i = 0; i < funcWidth; i++) begin
            onesCount = onesCount + popWidth'(diffBits[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            laneValidOut <= 1'b0;
            laneIsTop    <= 1'b0;
        end else if (advance) begin
            laneValidOut <= s1Valid;
            laneIsTop    <= s1IsTop;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            laneHit   <= s1Hit;
            laneCount <= s1Hit ? onesCount : '0;
        end
    end

    // a hit bot lies inside top so the gap equals the difference in ones
    assert property (@(posedge clock) disable iff (!rst)
        s1Valid && s1Hit |-> onesCount == popWidth'($countones(s1Top) - $countones(s1Bot)));

endmodule

// File: src/laneReducer.sv
`timescale 1ns/1ps

module laneReducer (
    input  logic                                                      clock,
    input  logic                                                      rst,
    input  logic                                                      advance,
    input  logic [boolFuncPkg::numLanes-1:0]                          laneValidOut,
    input  logic [boolFuncPkg::numLanes-1:0]                          laneIsTop,
    input  logic [boolFuncPkg::numLanes-1:0]                          laneHit,
    input  logic [boolFuncPkg::numLanes-1:0][boolFuncPkg::popWidth-1:0] laneCount,
    output logic                                                      outValid,
    output resultPkg::resultWord                                      result
);
    import boolFuncPkg::*;
    import resultPkg::*;

    logic                      itemValid;
    logic                      itemIsTop;
    logic [countWidth-1:0]     hitCount;
    logic [sumWidth-1:0]       laneSum;
    logic [botCountWidth-1:0]  botCount;    // bots since the last top
    logic [laneTotalWidth-1:0] laneTotal;   // hit lanes since the last top
    resultWord                 nextResult;

    // lanes run in lockstep so lane 0 speaks for all of them
    assign itemValid = laneValidOut[0];
    assign itemIsTop = laneIsTop[0];

    always_comb begin
        hitCount = '0;
        laneSum  = '0;
        for (int l = 0; l < numLanes; l++) begin
            if (laneHit[l]) begin
                hitCount = hitCount + countWidth'(1);
                laneSum  = laneSum + sumWidth'(laneCount[l]);
            end
        end
    end

    always_comb begin
        if (itemIsTop) begin
            nextResult.topView = '{
                isTop:     1'b1,
                botCount:  botCount,
                laneTotal: laneTotal
            };
        end else begin
            nextResult.botView = '{
                isTop:      1'b0,
                reserved:   2'b00,
                validCount: hitCount,
                sum:        laneSum
            };
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            outValid  <= 1'b0;
            botCount  <= '0;
            laneTotal <= '0;
        end else if (advance) begin
            outValid <= itemValid;
            if (itemValid && itemIsTop) begin
                // summary goes out and statistics restart for the new top
                botCount  <= '0;
                laneTotal <= '0;
            end else if (itemValid) begin
                botCount  <= botCount + botCountWidth'(1);
                laneTotal <= laneTotal + laneTotalWidth'(hitCount);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (advance && itemValid) begin
            result <= nextResult;
        end
    end

    // each lane carries the same item through the same stages
    assert property (@(posedge clock) disable iff (!rst)
        (&laneValidOut || ~|laneValidOut) &&
        (!itemValid || &laneIsTop || ~|laneIsTop));

endmodule

// File: src/permuteSumPipeline.sv
`timescale 1ns/1ps

module permuteSumPipeline (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 inValid,
    input  logic                 startNewTop,
    input  logic [63:0]          botLower,
    input  logic [63:0]          botUpper,
    input  logic                 outReady,
    output logic                 inReady,
    output logic                 outValid,
    output resultPkg::resultWord result
);
    import boolFuncPkg::*;

    logic                              advance;
    logic                              stageValid;
    logic                              stageIsTop;
    boolFunc                           stageBot;
    boolFunc                           currentTop;
    logic [numLanes-1:0]               laneValidOut;
    logic [numLanes-1:0]               laneIsTop;
    logic [numLanes-1:0]               laneHit;
    logic [numLanes-1:0][popWidth-1:0] laneCount;

    // whole pipe freezes while a result waits on the sink
    assign advance = !(outValid && !outReady);
    assign inReady = advance;

    botIngest i_ingest (
        .clock       (clock),
        .rst         (rst),
        .advance     (advance),
        .inValid     (inValid),
        .startNewTop (startNewTop),
        .botLower    (botLower),
        .botUpper    (botUpper),
        .stageValid  (stageValid),
        .stageIsTop  (stageIsTop),
        .stageBot    (stageBot),
        .currentTop  (currentTop)
    );

    for (genvar l = 0; l < numLanes; l++) begin : gLane
        permuteLane #(.laneIndex(l)) i_lane (
            .clock        (clock),
            .rst          (rst),
            .advance      (advance),
            .stageValid   (stageValid),
            .stageIsTop   (stageIsTop),
            .stageBot     (stageBot),
            .currentTop   (currentTop),
            .laneValidOut (laneValidOut[l]),
            .laneIsTop    (laneIsTop[l]),
            .laneHit      (laneHit[l]),
            .laneCount    (laneCount[l])
        );
    end

    laneReducer i_reducer (
        .clock        (clock),
        .rst          (rst),
        .advance      (advance),
        .laneValidOut (laneValidOut),
        .laneIsTop    (laneIsTop),
        .laneHit      (laneHit),
        .laneCount    (laneCount),
        .outValid     (outValid),
        .result       (result)
    );

    // a stalled result stays put until the sink takes it
    assert property (@(posedge clock) disable iff (!rst)
        outValid && !outReady |=> outValid && $stable(result));

endmodule

// File: verif/tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;  // 100 ns period
    end

    // reset low for the first 8 rising edges
    initial begin
        rst = 1'b0;
        repeat (8) @(posedge clock);
        #1 rst = 1'b1;
    end

endmodule

// File: verif/resultChecker.sv
`timescale 1ns/1ps

module resultChecker (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 inValid,
    input  logic                 inReady,
    input  logic                 outValid,
    input  logic                 outReady,
    input  resultPkg::resultWord result,
    input  logic [63:0]          expWord,
    input  int                   expGroup,
    input  logic                 allSent,
    output logic                 finished,
    output int                   errorCount,
    output int                   resultCount
);
    import boolFuncPkg::*;
    import resultPkg::*;

    logic [63:0] expQueue[$];    // expected words, in input order
    int          groupQueue[$];
    int          curGroup;
    int          groupResults;
    int          groupErrors;
    int          resetEdges;
    logic        stallSeen;
    resultWord   heldResult;

    initial begin
        finished     = 1'b0;
        errorCount   = 0;
        resultCount  = 0;
        curGroup     = 0;
        groupResults = 0;
        groupErrors  = 0;
        resetEdges   = 0;
        stallSeen    = 1'b0;
    end

    task automatic flagError();
        errorCount++;
        groupErrors++;
    endtask

    task automatic closeGroup();
        $display("group %0d done: %0d results, %0d errors", curGroup, groupResults,
            groupErrors);
    endtask

    task automatic reportOccupancy();
        real occupancy;
        if (result.topView.botCount == '0) begin
            $display("  top summary: no bots, occupancy undefined");
        end else begin
            occupancy = 100.0 * real'(result.topView.laneTotal)
                / (real'(numLanes) * real'(result.topView.botCount));
            $display("  top summary: %0d bots, %0d valid lanes, occupancy %.1f%%",
                result.topView.botCount, result.topView.laneTotal, occupancy);
        end
    endtask

    task automatic checkResult();
        logic [63:0] expected;
        int          group;
        if (expQueue.size() == 0) begin
            $display("unexpected result %h at %0t with no input in flight", result, $time);
            flagError();
        end else begin
            expected = expQueue.pop_front();
            group    = groupQueue.pop_front();
            if (group != curGroup) begin  // first result of the next group
                closeGroup();
                curGroup     = group;
                groupResults = 0;
                groupErrors  = 0;
            end
            groupResults++;
            resultCount++;
            if (result !== expected) begin
                $display("Mismatch at %0t: result %0d expected %h got %h", $time,
                    resultCount, expected, result);
                flagError();
            end else if (result.topView.isTop) begin
                reportOccupancy();
            end
        end
    endtask

    always @(posedge clock) begin
        if (!rst) begin
            resetEdges++;
            // registers only take the reset value at the first edge
            if (resetEdges > 1 && (outValid !== 1'b0 || inReady !== 1'b1)) begin
                $display("wrong state in reset at %0t: outValid %b, inReady %b", $time,
                    outValid, inReady);
                flagError();
            end
        end else if (!finished) begin
            if (stallSeen && (outValid !== 1'b1 || result !== heldResult)) begin
                $display("result dropped or changed during a stall at %0t", $time);
                flagError();
            end
            if (outValid && !outReady && inReady !== 1'b0) begin
                $display("inReady stayed high during a stall at %0t", $time);
                flagError();
            end
            if (outValid && outReady) begin
                checkResult();
            end
            if (inValid && inReady) begin
                expQueue.push_back(expWord);
                groupQueue.push_back(expGroup);
            end
            stallSeen  = outValid && !outReady;
            heldResult = result;
            if (allSent && expQueue.size() == 0) begin  // everything drained
                closeGroup();
                $display("done: %0d results checked, %0d errors", resultCount, errorCount);
                finished = 1'b1;
            end
        end
    end

endmodule

// File: verif/permuteSumTb.sv
`timescale 1ns/1ps

module permuteSumTb;
    import boolFuncPkg::*;
    import resultPkg::*;

    localparam int stallBots    = 15;
    localparam int streamBots   = 40;
    localparam int numRows      = 11 + stallBots + streamBots;
    localparam int timeoutLimit = numRows * 3 * 4 + 100;

    logic        clock;
    logic        rst;
    logic        inValid;
    logic        startNewTop;
    logic [63:0] botLower;
    logic [63:0] botUpper;
    logic        outReady;
    logic        inReady;
    logic        outValid;
    logic [63:0] result;
    logic [63:0] expWord;
    int          expGroup;
    logic        allSent;
    logic        finished;
    logic        accepted;
    int          errorCount;
    int          resultCount;
    int          cycleCount = 0;
    logic [31:0] lcgState;

    // stimulus table with the expected word worked out as rows are added
    logic        rowIsTop [numRows];
    boolFunc     rowWord  [numRows];
    logic [63:0] rowExp   [numRows];
    int          rowGroup [numRows];
    int          rowFill;
    boolFunc     modelTop;
    int          modelBots;
    int          modelLanes;

    tbClockGen i_clockGen (.clock(clock), .rst(rst));

    permuteSumPipeline i_dut (
        .clock       (clock),
        .rst         (rst),
        .inValid     (inValid),
        .startNewTop (startNewTop),
        .botLower    (botLower),
        .botUpper    (botUpper),
        .outReady    (outReady),
        .inReady     (inReady),
        .outValid    (outValid),
        .result      (result)
    );

    resultChecker i_checker (
        .clock       (clock),
        .rst         (rst),
        .inValid     (inValid),
        .inReady     (inReady),
        .outValid    (outValid),
        .outReady    (outReady),
        .result      (result),
        .expWord     (expWord),
        .expGroup    (expGroup),
        .allSent     (allSent),
        .finished    (finished),
        .errorCount  (errorCount),
        .resultCount (resultCount)
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic boolFunc randomFunc();
        boolFunc f;
        for (int w = 0; w < 4; w++) begin
            f[32*w +: 32] = nextRandom();
        end
        return f;
    endfunction

    function automatic int countOnes(input boolFunc f);
        int n;
        n = 0;
        for (int i = 0; i < funcWidth; i++) begin
            if (f[i]) n++;
        end
        return n;
    endfunction

    // each permuted bot that fits inside top adds the ones it leaves uncovered
    function automatic logic [63:0] scoreBot(input boolFunc top, input boolFunc bot);
        boolFunc permBot;
        int      hits;
        int      total;
        hits  = 0;
        total = 0;
        for (int l = 0; l < numLanes; l++) begin
            for (int i = 0; i < funcWidth; i++) begin
                permBot[i] = bot[permuteIndex(l, numVars'(i))];
            end
            if ((permBot & ~top) == '0) begin
                hits++;
                total += countOnes(top & ~permBot);
            end
        end
        return {1'b0, 2'b00, countWidth'(hits), sumWidth'(total)};
    endfunction

    task automatic addRow(input logic isTop, input boolFunc word, input int group);
        logic [63:0] expected;
        if (isTop) begin  // summary of the top being replaced
            expected   = {1'b1, botCountWidth'(modelBots), laneTotalWidth'(modelLanes)};
            modelTop   = word;
            modelBots  = 0;
            modelLanes = 0;
        end else begin
            expected = scoreBot(modelTop, word);
            modelBots++;
            modelLanes += int'(expected[sumWidth +: countWidth]);
        end
        rowIsTop[rowFill] = isTop;
        rowWord[rowFill]  = word;
        rowExp[rowFill]   = expected;
        rowGroup[rowFill] = group;
        rowFill++;
    endtask

    task automatic buildTable();
        boolFunc top;
        boolFunc bot;
        addRow(1'b1, {8{16'hFFFE}}, 0);  // minterm 0 of every block left empty
        addRow(1'b0, '0, 1);
        addRow(1'b0, '0, 1);
        addRow(1'b0, 128'h1, 2);  // misses under every lane
        addRow(1'b0, 128'h1_0000_0000, 2);
        addRow(1'b1, {96'h0, 32'hFFFF_FFFF}, 3);
        addRow(1'b0, {96'h0, 32'hFFFF_0000}, 3);  // only variable 4 set
        addRow(1'b0, {96'h0, 32'h00F0_000F}, 3);
        for (int g = 4; g <= 5; g++) begin
            top = randomFunc() | randomFunc();
            addRow(1'b1, top, g);
            for (int b = 0; b < (g == 4 ? stallBots : streamBots); b++) begin
                bot = randomFunc() & randomFunc() & randomFunc() & randomFunc() & top;
                addRow(1'b0, bot, g);
            end
        end
        addRow(1'b1, '0, 6);  // flushes the last summary
    endtask

    task automatic applyRow(input int r);
        logic [31:0] draw;
        inValid     = 1'b1;
        startNewTop = rowIsTop[r];
        botLower    = rowWord[r][63:0];
        botUpper    = rowWord[r][127:64];
        expWord     = rowExp[r];
        expGroup    = rowGroup[r];
        draw        = nextRandom();
        outReady    = rowGroup[r] <= 4 ? draw[16] : 1'b1;  // stream group runs unstalled
    endtask

    always_ff @(posedge clock) begin
        accepted <= inValid && inReady;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("hang: the run did not finish within %0d cycles", timeoutLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int r;
        inValid     = 1'b0;
        startNewTop = 1'b0;
        botLower    = '0;
        botUpper    = '0;
        outReady    = 1'b1;
        expWord     = '0;
        expGroup    = 0;
        allSent     = 1'b0;
        lcgState    = 32'd84884;
        rowFill     = 0;
        modelTop    = '0;
        modelBots   = 0;
        modelLanes  = 0;
        buildTable();
        wait (rst === 1'b1);
        r = 0;
        while (r < numRows) begin
            applyRow(r);
            @(posedge clock);
            #1;
            if (accepted) r++;  // hold the row until it is taken
        end
        inValid     = 1'b0;
        startNewTop = 1'b0;
        outReady    = 1'b1;
        allSent     = 1'b1;
        wait (finished === 1'b1);
        if (errorCount == 0 && resultCount == numRows) begin
            $display("** PASS **");
        end else begin
            if (resultCount != numRows) begin
                $display("only %0d of %0d results arrived", resultCount, numRows);
            end
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/boolFuncPkg.sv
common/resultPkg.sv
src/botIngest.sv
permuteLane/permuteLane.sv
src/laneReducer.sv
src/permuteSumPipeline.sv
verif/tbClockGen.sv
verif/resultChecker.sv
verif/permuteSumTb.sv

// File: run.sh
#!/bin/sh
# Build and run the permuteSumPipeline testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module permuteSumTb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qFx '** PASS **'; then
    exit 0
fi
exit 1
